// File: hw/commitPkg.sv
// Shared widths, types and encodings of the retire stage
// RP must be a power of two, so a tag {arch, phy} is also a flat written-bit index
// ROB_DEPTH must be a power of two, because the FIFO pointers wrap freely
// Machine mode only, cause codes follow the RISC-V privileged spec
package commitPkg;

	// Widths
	localparam int XLEN = 64;
	localparam int AB = 5;
	localparam int RB = 2;
	localparam int RP = 1 << RB;
	localparam int ROB_DEPTH = 8;
	localparam int ROB_AW = $clog2(ROB_DEPTH);

	typedef logic [XLEN-1:0] xlenT;
	typedef logic [RB-1:0] phyIdxT;
	typedef logic [AB-1:0] archIdxT;
	// Architectural index above physical copy index
	typedef logic [AB+RB-1:0] rdTagT;
	typedef logic [ROB_AW-1:0] robPtrT;
	typedef logic [ROB_AW:0] robCntT;
	// One bit per physical copy of every architectural register
	typedef logic [(1 << AB)*RP-1:0] wbVecT;
	typedef logic [7:0] robFlagT;

	// Flag positions inside robFlagT
	localparam int FLAG_BRANCH = 7;
	localparam int FLAG_LOAD = 6;
	localparam int FLAG_STORE = 5;
	localparam int FLAG_ECALL = 4;
	localparam int FLAG_EBREAK = 3;
	localparam int FLAG_MRET = 2;
	localparam int FLAG_INSTR_FAULT = 1;
	localparam int FLAG_ILLEGAL = 0;

	// Exception codes
	localparam int CAUSE_INSTR_FAULT = 1;
	localparam int CAUSE_ILLEGAL = 2;
	localparam int CAUSE_BREAK = 3;
	localparam int CAUSE_LOAD_FAULT = 5;
	localparam int CAUSE_STORE_FAULT = 7;
	localparam int CAUSE_ECALL_M = 11;
	// Interrupt codes, reported with mcause bit 63 set
	localparam int IRQ_SOFT = 3;
	localparam int IRQ_TIMER = 7;
	localparam int IRQ_EXT = 11;

	// mstatus fields
	localparam int MIE_BIT = 3;
	localparam int MPIE_BIT = 7;
	localparam int MPP_LO = 11;
	// mip and mie bits
	localparam int MSIP = 3;
	localparam int MTIP = 7;
	localparam int MEIP = 11;

	typedef enum logic [2:0] {
		SEL_MSTATUS,
		SEL_MIE,
		SEL_MIP,
		SEL_MEPC,
		SEL_MTVEC,
		SEL_MTIMECMP
	} csrSelT;

	typedef enum logic {
		RUN,
		FLUSH
	} commitStateT;

endpackage

// File: hw/reorderFifo.sv
// In-order retire record buffer, one push and one pop per cycle
// A push while full and a pop while empty are ignored
// Flush wins over a push and a pop in the same cycle
// Head outputs are stale while robEmpty is high
module reorderFifo (
	input logic clk,
	input logic rstN,
	input logic pushValid,
	input commitPkg::xlenT pushPc,
	input commitPkg::rdTagT pushRd,
	input commitPkg::robFlagT pushFlags,
	input logic pop,
	input logic flush,
	output logic full,
	output logic robEmpty,
	output commitPkg::xlenT headPc,
	output commitPkg::rdTagT headRd,
	output commitPkg::robFlagT headFlags
);
	import commitPkg::*;

	// Record payload
	xlenT pcMem [ROB_DEPTH];
	rdTagT rdMem [ROB_DEPTH];
	robFlagT flagMem [ROB_DEPTH];

	robPtrT wrPtr;
	robPtrT rdPtr;
	robCntT count;
	logic doPush;
	logic doPop;

	assign full = (count == robCntT'(ROB_DEPTH));
	assign robEmpty = (count == '0);
	assign doPush = pushValid & ~full;
	assign doPop = pop & ~robEmpty;

	// Payload write, a flushed entry is simply abandoned
	always_ff @(posedge clk) begin
		if (doPush) begin
			pcMem[wrPtr] <= pushPc;
			rdMem[wrPtr] <= pushRd;
			flagMem[wrPtr] <= pushFlags;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else if (flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1;
			if (doPop) rdPtr <= rdPtr + 1'b1;
			// Push and pop together leave the count alone
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head record
	assign headPc = pcMem[rdPtr];
	assign headRd = rdMem[rdPtr];
	assign headFlags = flagMem[rdPtr];

endmodule

// File: hw/wbLog.sv
// Written bit per physical copy, indexed directly by the rdTag
// Copy 0 of every register is the committed value after reset
// A writeback and a release of the same bit in one cycle leave it set
module wbLog (
	input logic clk,
	input logic rstN,
	input logic wbValid,
	input commitPkg::rdTagT wbTag,
	input commitPkg::wbVecT releaseMask,
	input commitPkg::rdTagT queryTag,
	output logic queryWritten
);
	import commitPkg::*;

	wbVecT written;
	wbVecT setMask;

	// One-hot of the written copy
	assign setMask = wbValid ? (wbVecT'(1) << wbTag) : '0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			// Only copy 0 of each register holds data
			written <= {(1 << AB){{(RP-1){1'b0}}, 1'b1}};
		end else begin
			written <= (written & ~releaseMask) | setMask;
		end
	end

	// Head query, same cycle
	assign queryWritten = written[queryTag];

endmodule

// File: hw/archMap.sv
// Committed physical copy of each architectural register
// One write port from retire, one read port for the head record
// Read is combinational and shows the value before a same-cycle write
module archMap (
	input logic clk,
	input logic rstN,
	input logic wrEn,
	input commitPkg::archIdxT wrArch,
	input commitPkg::phyIdxT wrPhy,
	input commitPkg::archIdxT rdArch,
	output commitPkg::phyIdxT rdPhy
);
	import commitPkg::*;

	phyIdxT mapPtr [1 << AB];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			// All registers start on copy 0
			for (int i = 0; i < (1 << AB); i++) begin
				mapPtr[i] <= '0;
			end
		end else if (wrEn) begin
			mapPtr[wrArch] <= wrPhy;
		end
	end

	// Old pointer of the head register
	assign rdPhy = mapPtr[rdArch];

endmodule

// File: hw/mTimer.sv
// Machine timer, mtime counts every clock cycle
// mtimecmp resets to all ones so no interrupt fires before it is written
// timerPending lags the compare by one cycle
module mTimer (
	input logic clk,
	input logic rstN,
	input logic cmpWrEn,
	input commitPkg::xlenT cmpWrData,
	output logic timerPending
);
	import commitPkg::*;

	xlenT mtime;
	xlenT mtimecmp;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mtime <= '0;
			mtimecmp <= '1;
			timerPending <= 1'b0;
		end else begin
			// Free running, wraps silently
			mtime <= mtime + 1'b1;
			if (cmpWrEn) mtimecmp <= cmpWrData;
			// Registered compare
			timerPending <= (mtime >= mtimecmp);
		end
	end

endmodule

// File: hw/trapCsr.sv
// Machine trap CSRs, mtval is not kept and reads as zero elsewhere
// MPP is fixed at 3 since only machine mode exists
// mtvec is direct mode only, its low two bits are cleared on write
// A trap or mret update wins over a configuration write to the same CSR
module trapCsr (
	input logic clk,
	input logic rstN,
	input logic cfgWrEn,
	input commitPkg::csrSelT cfgSel,
	input commitPkg::xlenT cfgWrData,
	input logic trapTake,
	input logic xretTake,
	input commitPkg::xlenT mstatusNext,
	input commitPkg::xlenT mepcNext,
	input commitPkg::xlenT mcauseNext,
	input logic timerPending,
	output commitPkg::xlenT mstatus,
	output commitPkg::xlenT mie,
	output commitPkg::xlenT mip,
	output commitPkg::xlenT mepc,
	output commitPkg::xlenT mcause,
	output commitPkg::xlenT mtvec
);
	import commitPkg::*;

	// Software and external pending bits, written by configuration only
	logic msipQ;
	logic meipQ;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mstatus <= '0;
			mstatus[MPP_LO +: 2] <= 2'b11;
			mie <= '0;
			mepc <= '0;
			mcause <= '0;
			mtvec <= '0;
			msipQ <= 1'b0;
			meipQ <= 1'b0;
		end else begin
			if (cfgWrEn) begin
				case (cfgSel)
					SEL_MSTATUS: begin
						mstatus <= cfgWrData;
						mstatus[MPP_LO +: 2] <= 2'b11;
					end
					SEL_MIE: mie <= cfgWrData;
					SEL_MIP: begin
						msipQ <= cfgWrData[MSIP];
						meipQ <= cfgWrData[MEIP];
					end
					SEL_MEPC: mepc <= cfgWrData;
					SEL_MTVEC: mtvec <= {cfgWrData[XLEN-1:2], 2'b00};
					// mtimecmp lives in the timer
					default: ;
				endcase
			end
			// Later assignments override the configuration write
			if (trapTake) begin
				mstatus <= mstatusNext;
				mepc <= mepcNext;
				mcause <= mcauseNext;
			end else if (xretTake) begin
				mstatus <= mstatusNext;
			end
		end
	end

	// Timer bit tracks the timer directly
	always_comb begin
		mip = '0;
		mip[MSIP] = msipQ;
		mip[MTIP] = timerPending;
		mip[MEIP] = meipQ;
	end

endmodule

// File: hw/commitUnit.sv
// Retire decision for the head of the reorder FIFO
// Interrupts are taken at the head only, so the FIFO must hold a record
// A trap beats an mret at the head, mret beats a mispredict
// redirectPc is zero on a mispredict, the branch unit owns that target
module commitUnit (
	input logic clk,
	input logic rstN,
	input logic robEmpty,
	input commitPkg::xlenT headPc,
	input commitPkg::rdTagT headRd,
	input commitPkg::robFlagT headFlags,
	input logic headWritten,
	input commitPkg::phyIdxT oldPhy,
	input logic misPredict,
	input logic lsuFault,
	input commitPkg::xlenT mstatus,
	input commitPkg::xlenT mie,
	input commitPkg::xlenT mip,
	input commitPkg::xlenT mepc,
	input commitPkg::xlenT mtvec,
	output logic robPop,
	output logic robFlush,
	output logic inFlush,
	output logic commitFire,
	output logic mapWrEn,
	output commitPkg::wbVecT releaseMask,
	output logic abort,
	output logic isTrap,
	output logic isXRet,
	output commitPkg::xlenT redirectPc,
	output logic trapTake,
	output commitPkg::xlenT mstatusNext,
	output commitPkg::xlenT mepcNext,
	output commitPkg::xlenT mcauseNext
);
	import commitPkg::*;

	commitStateT state;
	logic headValid;
	logic loadFault;
	logic storeFault;
	logic isException;
	logic irqExt;
	logic irqTimer;
	logic irqSoft;
	logic isInterrupt;
	logic [XLEN-2:0] causeCode;

	// Head is only considered while running
	assign inFlush = (state == FLUSH);
	assign headValid = ~robEmpty & ~inFlush;

	// Memory faults only count once the access has written back
	assign loadFault = lsuFault & headFlags[FLAG_LOAD] & headWritten;
	assign storeFault = lsuFault & headFlags[FLAG_STORE] & headWritten;
	assign isException = headFlags[FLAG_ECALL] | headFlags[FLAG_EBREAK]
		| headFlags[FLAG_INSTR_FAULT] | headFlags[FLAG_ILLEGAL] | loadFault | storeFault;

	// Enabled pending interrupts, gated by global MIE
	assign irqExt = mip[MEIP] & mie[MEIP] & mstatus[MIE_BIT];
	assign irqTimer = mip[MTIP] & mie[MTIP] & mstatus[MIE_BIT];
	assign irqSoft = mip[MSIP] & mie[MSIP] & mstatus[MIE_BIT];
	assign isInterrupt = irqExt | irqTimer | irqSoft;

	assign isTrap = headValid & (isInterrupt | isException);
	assign isXRet = headValid & headFlags[FLAG_MRET] & ~isTrap;
	assign abort = isTrap | isXRet | (headValid & headFlags[FLAG_BRANCH] & misPredict);
	assign trapTake = isTrap;

	// Retire, zero cycles from the head being written
	assign commitFire = headValid & headWritten & ~abort;
	assign robPop = commitFire;
	assign mapWrEn = commitFire;
	assign robFlush = abort;
	// Old copy of the head register goes back to rename
	assign releaseMask = commitFire ? (wbVecT'(1) << {headRd[RB +: AB], oldPhy}) : '0;

	// Cause priority, interrupts first
	always_comb begin
		if (irqExt) causeCode = (XLEN-1)'(IRQ_EXT);
		else if (irqTimer) causeCode = (XLEN-1)'(IRQ_TIMER);
		else if (irqSoft) causeCode = (XLEN-1)'(IRQ_SOFT);
		else if (headFlags[FLAG_INSTR_FAULT]) causeCode = (XLEN-1)'(CAUSE_INSTR_FAULT);
		else if (headFlags[FLAG_ILLEGAL]) causeCode = (XLEN-1)'(CAUSE_ILLEGAL);
		else if (headFlags[FLAG_EBREAK]) causeCode = (XLEN-1)'(CAUSE_BREAK);
		else if (headFlags[FLAG_ECALL]) causeCode = (XLEN-1)'(CAUSE_ECALL_M);
		else if (loadFault) causeCode = (XLEN-1)'(CAUSE_LOAD_FAULT);
		else causeCode = (XLEN-1)'(CAUSE_STORE_FAULT);
	end
	assign mcauseNext = {isInterrupt, causeCode};
	// Faulting or interrupted instruction restarts from its own pc
	assign mepcNext = headPc;

	always_comb begin
		mstatusNext = mstatus;
		if (isXRet) begin
			mstatusNext[MIE_BIT] = mstatus[MPIE_BIT];
			mstatusNext[MPIE_BIT] = 1'b1;
		end else begin
			mstatusNext[MPIE_BIT] = mstatus[MIE_BIT];
			mstatusNext[MIE_BIT] = 1'b0;
			mstatusNext[MPP_LO +: 2] = 2'b11;
		end
	end

	assign redirectPc = isXRet ? mepc : (isTrap ? mtvec : '0);

	// One FLUSH cycle after every abort
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= RUN;
		end else begin
			case (state)
				RUN: if (abort) state <= FLUSH;
				default: state <= RUN;
			endcase
		end
	end

endmodule

// File: hw/commitCore.sv
// Retire stage top, dispatch sees a ready/valid push into the reorder FIFO
// A push accepted in an abort cycle is dropped by the flush
// commitPc and commitRd are only meaningful while commitFire is high
module commitCore (
	input logic clk,
	input logic rstN,
	input logic pushValid,
	input commitPkg::xlenT pushPc,
	input commitPkg::rdTagT pushRd,
	input commitPkg::robFlagT pushFlags,
	input logic wbValid,
	input commitPkg::rdTagT wbTag,
	input logic misPredict,
	input logic lsuFault,
	input logic cfgWrEn,
	input commitPkg::csrSelT cfgSel,
	input commitPkg::xlenT cfgWrData,
	output logic pushReady,
	output logic commitFire,
	output commitPkg::xlenT commitPc,
	output commitPkg::rdTagT commitRd,
	output commitPkg::wbVecT releaseMask,
	output logic abort,
	output logic isTrap,
	output logic isXRet,
	output commitPkg::xlenT redirectPc,
	output commitPkg::xlenT mcause,
	output commitPkg::xlenT mepc,
	output commitPkg::xlenT mstatus
);
	import commitPkg::*;

	logic full;
	logic robEmpty;
	xlenT headPc;
	rdTagT headRd;
	robFlagT headFlags;
	logic robPop;
	logic robFlush;
	logic inFlush;
	logic headWritten;
	phyIdxT oldPhy;
	logic mapWrEn;
	logic timerPending;
	logic trapTake;
	xlenT mstatusNext;
	xlenT mepcNext;
	xlenT mcauseNext;
	xlenT mie;
	xlenT mip;
	xlenT mtvec;

	// No dispatch while full or flushing
	assign pushReady = ~full & ~inFlush;
	assign commitPc = headPc;
	assign commitRd = headRd;

	reorderFifo uFifo (
		.clk(clk), .rstN(rstN), .pushValid(pushValid & pushReady),
		.pushPc(pushPc), .pushRd(pushRd), .pushFlags(pushFlags),
		.pop(robPop), .flush(robFlush), .full(full), .robEmpty(robEmpty),
		.headPc(headPc), .headRd(headRd), .headFlags(headFlags)
	);

	wbLog uWbLog (
		.clk(clk), .rstN(rstN), .wbValid(wbValid), .wbTag(wbTag),
		.releaseMask(releaseMask), .queryTag(headRd), .queryWritten(headWritten)
	);

	// Map write takes the head's own copy
	archMap uMap (
		.clk(clk), .rstN(rstN), .wrEn(mapWrEn), .wrArch(headRd[RB +: AB]),
		.wrPhy(headRd[RB-1:0]), .rdArch(headRd[RB +: AB]), .rdPhy(oldPhy)
	);

	mTimer uTimer (
		.clk(clk), .rstN(rstN), .cmpWrEn(cfgWrEn & (cfgSel == SEL_MTIMECMP)),
		.cmpWrData(cfgWrData), .timerPending(timerPending)
	);

	trapCsr uCsr (
		.clk(clk), .rstN(rstN), .cfgWrEn(cfgWrEn), .cfgSel(cfgSel),
		.cfgWrData(cfgWrData), .trapTake(trapTake), .xretTake(isXRet),
		.mstatusNext(mstatusNext), .mepcNext(mepcNext), .mcauseNext(mcauseNext),
		.timerPending(timerPending), .mstatus(mstatus), .mie(mie), .mip(mip),
		.mepc(mepc), .mcause(mcause), .mtvec(mtvec)
	);

	commitUnit uCommit (
		.clk(clk), .rstN(rstN), .robEmpty(robEmpty), .headPc(headPc),
		.headRd(headRd), .headFlags(headFlags), .headWritten(headWritten),
		.oldPhy(oldPhy), .misPredict(misPredict), .lsuFault(lsuFault),
		.mstatus(mstatus), .mie(mie), .mip(mip), .mepc(mepc), .mtvec(mtvec),
		.robPop(robPop), .robFlush(robFlush), .inFlush(inFlush),
		.commitFire(commitFire), .mapWrEn(mapWrEn), .releaseMask(releaseMask),
		.abort(abort), .isTrap(isTrap), .isXRet(isXRet), .redirectPc(redirectPc),
		.trapTake(trapTake), .mstatusNext(mstatusNext), .mepcNext(mepcNext),
		.mcauseNext(mcauseNext)
	);

endmodule

// File: test/commitTb.sv
// Self-checking testbench for commitCore
// Inputs change on the falling edge and outputs are sampled a quarter period later
// A cycle model of FIFO, written bits, map, CSRs and timer runs in lockstep with the DUT
// Random stimulus comes from a 64-bit xorshift generator with a fixed seed
module commitTb;
	import commitPkg::*;

	logic clk;
	logic rstN;
	logic pushValid;
	xlenT pushPc;
	rdTagT pushRd;
	robFlagT pushFlags;
	logic wbValid;
	rdTagT wbTag;
	logic misPredict;
	logic lsuFault;
	logic cfgWrEn;
	csrSelT cfgSel;
	xlenT cfgWrData;
	logic pushReady;
	logic commitFire;
	xlenT commitPc;
	rdTagT commitRd;
	wbVecT releaseMask;
	logic abort;
	logic isTrap;
	logic isXRet;
	xlenT redirectPc;
	xlenT mcause;
	xlenT mepc;
	xlenT mstatus;

	// Staged inputs that the next falling edge applies
	logic sPushValid;
	xlenT sPushPc;
	rdTagT sPushRd;
	robFlagT sPushFlags;
	logic sWbValid;
	rdTagT sWbTag;
	logic sMisPredict;
	logic sLsuFault;
	logic sCfgWrEn;
	csrSelT sCfgSel;
	xlenT sCfgWrData;

	// Outputs seen in the last stepped cycle
	logic lastReady;
	logic lastAbort;
	logic lastFire;
	xlenT lastRedirect;

	// Reference model state
	xlenT qPc [$];
	rdTagT qRd [$];
	robFlagT qFlags [$];
	wbVecT mWritten;
	phyIdxT mMap [1 << AB];
	xlenT mMstatus;
	xlenT mMie;
	xlenT mMepc;
	xlenT mMcause;
	xlenT mMtvec;
	xlenT mMtime;
	xlenT mMtimecmp;
	logic mMsip;
	logic mMeip;
	logic mTimerPending;
	logic mFlush;

	logic [63:0] rngState;
	int mismatchCount;
	int otherCount;
	int retireCount;
	int abortCount;

	commitCore DUT (
		.clk(clk), .rstN(rstN), .pushValid(pushValid), .pushPc(pushPc),
		.pushRd(pushRd), .pushFlags(pushFlags), .wbValid(wbValid), .wbTag(wbTag),
		.misPredict(misPredict), .lsuFault(lsuFault), .cfgWrEn(cfgWrEn),
		.cfgSel(cfgSel), .cfgWrData(cfgWrData), .pushReady(pushReady),
		.commitFire(commitFire), .commitPc(commitPc), .commitRd(commitRd),
		.releaseMask(releaseMask), .abort(abort), .isTrap(isTrap), .isXRet(isXRet),
		.redirectPc(redirectPc), .mcause(mcause), .mepc(mepc), .mstatus(mstatus)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic checkXlen(input string name, input xlenT got, input xlenT exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkTag(input string name, input rdTagT got, input rdTagT exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkMask(input string name, input wbVecT got, input wbVecT exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	function automatic logic [63:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 7;
		rngState ^= rngState << 17;
		return rngState;
	endfunction

	// First copy above register 0 that holds no data
	function automatic rdTagT freeTag();
		for (int i = RP; i < (1 << AB) * RP; i++) begin
			if (!mWritten[i]) return rdTagT'(i);
		end
		return rdTagT'(RP + 1);
	endfunction

	task automatic modelReset();
		qPc.delete();
		qRd.delete();
		qFlags.delete();
		mWritten = '0;
		for (int i = 0; i < (1 << AB); i++) begin
			mWritten[i * RP] = 1'b1;
			mMap[i] = '0;
		end
		mMstatus = '0;
		mMstatus[MPP_LO +: 2] = 2'b11;
		mMie = '0;
		mMepc = '0;
		mMcause = '0;
		mMtvec = '0;
		mMtime = '0;
		mMtimecmp = '1;
		mMsip = 1'b0;
		mMeip = 1'b0;
		mTimerPending = 1'b0;
		mFlush = 1'b0;
	endtask

	// Compare the current outputs, then advance the model over the rising edge
	task automatic modelCycle();
		logic headValid;
		logic written;
		logic memLoad;
		logic memStore;
		logic except;
		logic irqExt;
		logic irqTimer;
		logic irqSoft;
		logic expTrap;
		logic expXRet;
		logic expAbort;
		logic expFire;
		logic expReady;
		robFlagT flags;
		xlenT pc;
		rdTagT rd;
		archIdxT arch;
		xlenT cause;
		xlenT newStatus;
		wbVecT rel;
		headValid = (qPc.size() > 0) && !mFlush;
		flags = '0;
		pc = '0;
		rd = '0;
		if (headValid) begin
			flags = qFlags[0];
			pc = qPc[0];
			rd = qRd[0];
		end
		written = mWritten[rd];
		// Memory faults need the access to be written back
		memLoad = lsuFault && flags[FLAG_LOAD] && written;
		memStore = lsuFault && flags[FLAG_STORE] && written;
		except = flags[FLAG_ECALL] || flags[FLAG_EBREAK] || flags[FLAG_INSTR_FAULT]
			|| flags[FLAG_ILLEGAL] || memLoad || memStore;
		irqExt = mMeip && mMie[MEIP] && mMstatus[MIE_BIT];
		irqTimer = mTimerPending && mMie[MTIP] && mMstatus[MIE_BIT];
		irqSoft = mMsip && mMie[MSIP] && mMstatus[MIE_BIT];
		expTrap = headValid && (irqExt || irqTimer || irqSoft || except);
		expXRet = headValid && flags[FLAG_MRET] && !expTrap;
		expAbort = expTrap || expXRet || (headValid && flags[FLAG_BRANCH] && misPredict);
		expFire = headValid && written && !expAbort;
		expReady = (qPc.size() < ROB_DEPTH) && !mFlush;
		arch = rd[RB +: AB];
		rel = expFire ? (wbVecT'(1) << {arch, mMap[arch]}) : '0;
		// Interrupts come first and exceptions follow in fixed order
		if (irqExt) cause = {1'b1, 63'(IRQ_EXT)};
		else if (irqTimer) cause = {1'b1, 63'(IRQ_TIMER)};
		else if (irqSoft) cause = {1'b1, 63'(IRQ_SOFT)};
		else if (flags[FLAG_INSTR_FAULT]) cause = xlenT'(CAUSE_INSTR_FAULT);
		else if (flags[FLAG_ILLEGAL]) cause = xlenT'(CAUSE_ILLEGAL);
		else if (flags[FLAG_EBREAK]) cause = xlenT'(CAUSE_BREAK);
		else if (flags[FLAG_ECALL]) cause = xlenT'(CAUSE_ECALL_M);
		else if (memLoad) cause = xlenT'(CAUSE_LOAD_FAULT);
		else cause = xlenT'(CAUSE_STORE_FAULT);
		newStatus = mMstatus;
		if (expXRet) begin
			newStatus[MIE_BIT] = mMstatus[MPIE_BIT];
			newStatus[MPIE_BIT] = 1'b1;
		end else begin
			newStatus[MPIE_BIT] = mMstatus[MIE_BIT];
			newStatus[MIE_BIT] = 1'b0;
			newStatus[MPP_LO +: 2] = 2'b11;
		end

		checkBit("pushReady", pushReady, expReady);
		checkBit("commitFire", commitFire, expFire);
		checkBit("abort", abort, expAbort);
		checkBit("isTrap", isTrap, expTrap);
		checkBit("isXRet", isXRet, expXRet);
		checkMask("releaseMask", releaseMask, rel);
		checkXlen("mstatus", mstatus, mMstatus);
		checkXlen("mepc", mepc, mMepc);
		checkXlen("mcause", mcause, mMcause);
		if (expFire) begin
			checkXlen("commitPc", commitPc, pc);
			checkTag("commitRd", commitRd, rd);
		end
		if (expTrap) checkXlen("redirectPc", redirectPc, mMtvec);
		if (expXRet) checkXlen("redirectPc", redirectPc, mMepc);

		if (expFire) retireCount++;
		if (expAbort) abortCount++;
		// A flush also drops a push of the same cycle
		if (expAbort) begin
			qPc.delete();
			qRd.delete();
			qFlags.delete();
		end else begin
			if (expFire) begin
				qPc.delete(0);
				qRd.delete(0);
				qFlags.delete(0);
			end
			if (pushValid && expReady) begin
				qPc.push_back(pushPc);
				qRd.push_back(pushRd);
				qFlags.push_back(pushFlags);
			end
		end
		// Set beats release on the same copy
		mWritten = (mWritten & ~rel) | (wbValid ? (wbVecT'(1) << wbTag) : '0);
		if (expFire) mMap[arch] = rd[RB-1:0];
		// Compare uses mtime and mtimecmp before the edge
		mTimerPending = (mMtime >= mMtimecmp);
		mMtime++;
		if (cfgWrEn) begin
			case (cfgSel)
				SEL_MSTATUS: begin
					mMstatus = cfgWrData;
					mMstatus[MPP_LO +: 2] = 2'b11;
				end
				SEL_MIE: mMie = cfgWrData;
				SEL_MIP: begin
					mMsip = cfgWrData[MSIP];
					mMeip = cfgWrData[MEIP];
				end
				SEL_MEPC: mMepc = cfgWrData;
				SEL_MTVEC: mMtvec = cfgWrData & ~xlenT'(3);
				SEL_MTIMECMP: mMtimecmp = cfgWrData;
				default: ;
			endcase
		end
		// Trap update overrides a configuration write
		if (expTrap) begin
			mMstatus = newStatus;
			mMepc = pc;
			mMcause = cause;
		end else if (expXRet) begin
			mMstatus = newStatus;
		end
		mFlush = !mFlush && expAbort;
	endtask

	task automatic stepCycle();
		@(negedge clk);
		pushValid = sPushValid;
		pushPc = sPushPc;
		pushRd = sPushRd;
		pushFlags = sPushFlags;
		wbValid = sWbValid;
		wbTag = sWbTag;
		misPredict = sMisPredict;
		lsuFault = sLsuFault;
		cfgWrEn = sCfgWrEn;
		cfgSel = sCfgSel;
		cfgWrData = sCfgWrData;
		#5;
		lastReady = pushReady;
		lastAbort = abort;
		lastFire = commitFire;
		lastRedirect = redirectPc;
		modelCycle();
		// Strobes last one cycle while misPredict and lsuFault hold until changed
		sPushValid = 1'b0;
		sWbValid = 1'b0;
		sCfgWrEn = 1'b0;
	endtask

	task automatic stagePush(input xlenT pc, input rdTagT rd, input robFlagT flags);
		sPushValid = 1'b1;
		sPushPc = pc;
		sPushRd = rd;
		sPushFlags = flags;
	endtask

	task automatic cfgWrite(input csrSelT sel, input xlenT data);
		sCfgWrEn = 1'b1;
		sCfgSel = sel;
		sCfgWrData = data;
		stepCycle();
	endtask

	task automatic waitAbort(input string what);
		int n;
		n = 0;
		lastAbort = 1'b0;
		while (!lastAbort && n < 64) begin
			stepCycle();
			n++;
		end
		if (!lastAbort) begin
			otherCount++;
			$display("Timeout at %0t: no abort seen for %s", $time, what);
		end
	endtask

	// Write back the head copy each cycle until the FIFO is empty
	task automatic drainFifo();
		int n;
		n = 0;
		while (qPc.size() > 0 && n < 200) begin
			sWbValid = 1'b1;
			sWbTag = qRd[0];
			stepCycle();
			n++;
		end
		if (qPc.size() > 0) begin
			otherCount++;
			$display("Timeout at %0t: reorder FIFO did not drain", $time);
		end
	endtask

	task automatic randomPhase(input int cycles);
		logic [63:0] r;
		logic [63:0] r2;
		int idx;
		for (int i = 0; i < cycles; i++) begin
			r = nextRand();
			r2 = nextRand();
			sPushValid = r[0] | r[1];
			sPushPc = {r2[63:2], 2'b00};
			sPushRd = r[12:6];
			// Some records are branches and a few of them mispredict at the head
			sPushFlags = (r[13] & r[14]) ? (robFlagT'(1) << FLAG_BRANCH) : '0;
			sMisPredict = r[15] & r[16] & r[17];
			sWbValid = r[20] | r[21];
			// Mostly copies waiting in the FIFO in any order
			if (qRd.size() > 0 && r[22]) begin
				idx = int'(r[31:24]) % qRd.size();
				sWbTag = qRd[idx];
			end else begin
				sWbTag = r[38:32];
			end
			stepCycle();
		end
		sMisPredict = 1'b0;
	endtask

	task automatic trapCase(input robFlagT flags, input logic memFault, input xlenT code);
		xlenT pc;
		rdTagT tag;
		pc = nextRand() & ~xlenT'(3);
		tag = freeTag();
		cfgWrite(SEL_MSTATUS, xlenT'(1) << MIE_BIT);
		stagePush(pc, tag, flags);
		// Load and store faults need the access written back
		sWbValid = memFault;
		sWbTag = tag;
		sLsuFault = memFault;
		stepCycle();
		waitAbort("exception");
		sLsuFault = 1'b0;
		stepCycle();
		checkXlen("mcause", mcause, code);
		checkXlen("mepc", mepc, pc);
		checkBit("mstatus.MIE", mstatus[MIE_BIT], 1'b0);
		checkBit("mstatus.MPIE", mstatus[MPIE_BIT], 1'b1);
		checkBit("mstatus.MPP", &mstatus[MPP_LO +: 2], 1'b1);
	endtask

	initial begin
		xlenT pc;
		xlenT savedCause;
		xlenT savedEpc;
		rngState = 64'd29;
		mismatchCount = 0;
		otherCount = 0;
		retireCount = 0;
		abortCount = 0;
		rstN = 1'b0;
		pushValid = 1'b0;
		pushPc = '0;
		pushRd = '0;
		pushFlags = '0;
		wbValid = 1'b0;
		wbTag = '0;
		misPredict = 1'b0;
		lsuFault = 1'b0;
		cfgWrEn = 1'b0;
		cfgSel = SEL_MSTATUS;
		cfgWrData = '0;
		sPushValid = 1'b0;
		sPushPc = '0;
		sPushRd = '0;
		sPushFlags = '0;
		sWbValid = 1'b0;
		sWbTag = '0;
		sMisPredict = 1'b0;
		sLsuFault = 1'b0;
		sCfgWrEn = 1'b0;
		sCfgSel = SEL_MSTATUS;
		sCfgWrData = '0;
		modelReset();
		repeat (16) @(posedge clk);
		// First modelled edge is the one right after release
		@(negedge clk);
		rstN = 1'b1;
		#5;
		modelCycle();

		// In-order retire and map updates under random traffic
		randomPhase(600);
		drainFifo();
		if (retireCount < 100) begin
			otherCount++;
			$display("Too few retirements in random traffic: %0d", retireCount);
		end
		cfgWrite(SEL_MTVEC, 64'h0000_0000_8000_0100);

		// Mispredicted branch at the head
		savedCause = mMcause;
		savedEpc = mMepc;
		stagePush(nextRand() & ~xlenT'(3), freeTag(), robFlagT'(1) << FLAG_BRANCH);
		// Branch is written back so only the abort can hold off its retire
		sWbValid = 1'b1;
		sWbTag = sPushRd;
		sMisPredict = 1'b1;
		stepCycle();
		waitAbort("mispredict");
		sMisPredict = 1'b0;
		checkBit("commitFire on mispredict", lastFire, 1'b0);
		stepCycle();
		checkBit("pushReady in flush", lastReady, 1'b0);
		stepCycle();
		checkBit("pushReady after flush", lastReady, 1'b1);
		checkXlen("mcause", mcause, savedCause);
		checkXlen("mepc", mepc, savedEpc);

		// Exceptions
		trapCase(robFlagT'(1) << FLAG_ECALL, 1'b0, xlenT'(CAUSE_ECALL_M));
		trapCase(robFlagT'(1) << FLAG_EBREAK, 1'b0, xlenT'(CAUSE_BREAK));
		trapCase(robFlagT'(1) << FLAG_ILLEGAL, 1'b0, xlenT'(CAUSE_ILLEGAL));
		trapCase(robFlagT'(1) << FLAG_INSTR_FAULT, 1'b0, xlenT'(CAUSE_INSTR_FAULT));
		trapCase(robFlagT'(1) << FLAG_LOAD, 1'b1, xlenT'(CAUSE_LOAD_FAULT));
		trapCase(robFlagT'(1) << FLAG_STORE, 1'b1, xlenT'(CAUSE_STORE_FAULT));
		// Illegal outranks ecall on the same record
		trapCase((robFlagT'(1) << FLAG_ECALL) | (robFlagT'(1) << FLAG_ILLEGAL), 1'b0,
			xlenT'(CAUSE_ILLEGAL));

		// mret returns to the last trap pc
		// MIE set and MPIE clear so both bits change on return
		cfgWrite(SEL_MSTATUS, xlenT'(1) << MIE_BIT);
		savedEpc = mMepc;
		stagePush(nextRand() & ~xlenT'(3), freeTag(), robFlagT'(1) << FLAG_MRET);
		stepCycle();
		waitAbort("mret");
		checkXlen("redirectPc on mret", lastRedirect, savedEpc);
		stepCycle();
		checkBit("mstatus.MIE", mstatus[MIE_BIT], 1'b0);
		checkBit("mstatus.MPIE", mstatus[MPIE_BIT], 1'b1);

		// Timer interrupt on a stalled head
		cfgWrite(SEL_MSTATUS, xlenT'(1) << MIE_BIT);
		cfgWrite(SEL_MIE, xlenT'(1) << MTIP);
		pc = nextRand() & ~xlenT'(3);
		stagePush(pc, freeTag(), '0);
		stepCycle();
		cfgWrite(SEL_MTIMECMP, mMtime + 6);
		waitAbort("timer interrupt");
		stepCycle();
		checkXlen("mcause", mcause, {1'b1, 63'(IRQ_TIMER)});
		checkXlen("mepc", mepc, pc);
		repeat (4) stepCycle();

		$display("Errors: %0d mismatches, %0d other failures (%0d retired, %0d aborts)",
			mismatchCount, otherCount, retireCount, abortCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
hw/commitPkg.sv
hw/reorderFifo.sv
hw/wbLog.sv
hw/archMap.sv
hw/mTimer.sv
hw/trapCsr.sv
hw/commitUnit.sv
hw/commitCore.sv
test/commitTb.sv
